/* csr_unit.f */
design/csr_pkg.sv
design/csr_decode.sv
design/csr_execute.sv
design/csr_regfile.sv
design/csr_timer.sv
design/csr_intr.sv
design/csr_unit.sv
bench/csr_unit_tb.sv

/* Makefile */
TOOL       := verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall
TOP        := csr_unit_tb
FLIST      := csr_unit.f
BUILD      := obj_dir
LOG        := sim.log
PASS_MSG   := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/csr_unit_tb.sv */
`timescale 1ns/1ps

module csr_unit_tb
    import csr_pkg::*;
();

    localparam logic [31:0] NOP = 32'h0000_0013;

    logic        clk;
    logic        rst_n;
    logic        inst_vld;
    logic [31:0] inst;
    logic [5:0]  inst_id;
    logic [31:0] inst_pc;
    logic [31:0] rs1_val;
    logic [6:0]  rd_idx;
    logic        rd_en;
    logic        c_ext;
    logic        is_intr;
    logic        intr_ack;
    logic        meip;
    logic        msip;
    logic        reg_wr_en;
    logic [6:0]  reg_index;
    logic [31:0] reg_val;
    logic [5:0]  reg_inst_idx;
    logic        commit_en;
    logic [31:0] next_pc;
    logic        pc_update_en;
    logic [31:0] pc_val;
    logic        intr_req;

    // expected response of the current strobe
    string       cur_name;
    logic        exp_csr;
    logic        exp_reg_wr;
    logic        exp_redirect;
    logic [31:0] exp_old;
    logic [31:0] exp_pc_val;
    logic [31:0] exp_next_pc;
    logic [31:0] sampled_val;

    // model of the machine CSR state
    logic        m_mstatus_mie;
    logic        m_mpie;
    logic [31:0] m_mie;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;
    logic [63:0] m_mtimecmp;
    logic [63:0] model_cycle;

    csr_unit uut (
        .clk(clk), .rst_n(rst_n), .inst_vld(inst_vld), .inst(inst), .inst_id(inst_id),
        .inst_pc(inst_pc), .rs1_val(rs1_val), .rd_idx(rd_idx), .rd_en(rd_en), .c_ext(c_ext),
        .is_intr(is_intr), .intr_ack(intr_ack), .meip(meip), .msip(msip),
        .reg_wr_en(reg_wr_en), .reg_index(reg_index), .reg_val(reg_val),
        .reg_inst_idx(reg_inst_idx), .commit_en(commit_en), .next_pc(next_pc),
        .pc_update_en(pc_update_en), .pc_val(pc_val), .intr_req(intr_req)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // counter starts at 0 and steps on every edge out of reset
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_cycle <= 64'd0;
        end else begin
            model_cycle <= model_cycle + 64'd1;
        end
    end

    // ====================
    // reference model
    // ====================
    function automatic logic [31:0] csr_value(input logic [11:0] a);
        logic [31:0] mip;
        logic [31:0] mst;
        mip = 32'd0;
        mip[11] = meip;
        mip[7] = (model_cycle > m_mtimecmp);
        mip[3] = msip;
        mst = 32'd0;
        mst[3] = m_mstatus_mie;
        mst[7] = m_mpie;
        case (a)
            CSR_CYCLE, CSR_TIME, CSR_MCYCLE:    return model_cycle[31:0];
            CSR_CYCLEH, CSR_TIMEH, CSR_MCYCLEH: return model_cycle[63:32];
            CSR_MSTATUS:                        return mst;
            CSR_MISA:                           return 32'h4000_0100;
            CSR_MIE:                            return m_mie;
            CSR_MTVEC:                          return m_mtvec;
            CSR_MSCRATCH:                       return m_mscratch;
            CSR_MEPC:                           return m_mepc;
            CSR_MCAUSE:                         return m_mcause;
            CSR_MTVAL:                          return m_mtval;
            CSR_MIP:                            return mip;
            CSR_MTIMECMP:                       return m_mtimecmp[31:0];
            CSR_MTIMECMPH:                      return m_mtimecmp[63:32];
            default:                            return 32'd0;
        endcase
    endfunction

    function automatic void store_csr(input logic [11:0] a, input logic [31:0] d);
        case (a)
            CSR_MSTATUS: begin
                m_mstatus_mie = d[3];
                m_mpie = d[7];
            end
            CSR_MIE:       m_mie = d & 32'h0000_0888;
            CSR_MTVEC: begin
                m_mtvec[31:2] = d[31:2];
                // mode only taken when bit 1 is clear
                if (!d[1]) begin
                    m_mtvec[1:0] = d[1:0];
                end
            end
            CSR_MSCRATCH:  m_mscratch = d;
            CSR_MEPC:      m_mepc = d;
            CSR_MCAUSE:    m_mcause = d;
            CSR_MTVAL:     m_mtval = d;
            CSR_MTIMECMP:  m_mtimecmp[31:0] = d;
            CSR_MTIMECMPH: m_mtimecmp[63:32] = d;
            default:       ;
        endcase
    endfunction

    function automatic void predict(input logic [31:0] ins, input logic [31:0] rs1,
                                    input logic [31:0] pc, input logic rde, input logic cx);
        logic [2:0]  f3;
        logic [11:0] addr;
        logic [31:0] opnd;
        logic [31:0] nv;
        logic        sys;
        f3 = ins[14:12];
        addr = ins[31:20];
        sys = (ins[6:0] == 7'b1110011);
        exp_csr = 1'b0;
        exp_redirect = 1'b0;
        exp_pc_val = 32'd0;
        exp_old = csr_value(addr);
        if (sys && (f3 != 3'b000) && (f3 != 3'b100)) begin
            exp_csr = 1'b1;
            opnd = f3[2] ? {27'd0, ins[19:15]} : rs1;
            case (f3[1:0])
                2'b01:   nv = opnd;
                2'b10:   nv = exp_old | opnd;
                default: nv = exp_old & ~opnd;
            endcase
            store_csr(addr, nv);
        end else if (sys && (f3 == 3'b000) && ((addr == 12'h000) || (addr == 12'h001))) begin
            exp_redirect = 1'b1;
            exp_pc_val = m_mtvec;
            m_mepc = pc;
            m_mtval = ins;
            m_mcause = (addr == 12'h000) ? 32'd11 : 32'd3;
            m_mpie = m_mstatus_mie;
            m_mstatus_mie = 1'b0;
        end else if (sys && (f3 == 3'b000) && (addr == 12'h302)) begin
            exp_redirect = 1'b1;
            exp_pc_val = m_mepc;
            m_mstatus_mie = m_mpie;
            m_mpie = 1'b1;
        end
        exp_reg_wr = exp_csr && rde;
        exp_next_pc = exp_redirect ? exp_pc_val : pc + (cx ? 32'd2 : 32'd4);
    endfunction

    // ====================
    // error handling
    // ====================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_fail(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    // compare at the falling edge, outputs settled since the drive
    always @(negedge clk) begin
        if (rst_n && inst_vld) begin
            assert (commit_en)
                else report_fail($sformatf("%s commit_en", cur_name), 32'd1, 32'(commit_en));
            assert (reg_index == rd_idx)
                else report_fail($sformatf("%s reg_index", cur_name),
                                 32'(rd_idx), 32'(reg_index));
            assert (reg_inst_idx == inst_id)
                else report_fail($sformatf("%s reg_inst_idx", cur_name),
                                 32'(inst_id), 32'(reg_inst_idx));
            assert (reg_wr_en == exp_reg_wr)
                else report_fail($sformatf("%s reg_wr_en", cur_name),
                                 32'(exp_reg_wr), 32'(reg_wr_en));
            assert (!exp_csr || (reg_val == exp_old))
                else report_fail($sformatf("%s reg_val", cur_name), exp_old, reg_val);
            assert (pc_update_en == exp_redirect)
                else report_fail($sformatf("%s pc_update_en", cur_name),
                                 32'(exp_redirect), 32'(pc_update_en));
            assert (!exp_redirect || (pc_val == exp_pc_val))
                else report_fail($sformatf("%s pc_val", cur_name), exp_pc_val, pc_val);
            assert (next_pc == exp_next_pc)
                else report_fail($sformatf("%s next_pc", cur_name), exp_next_pc, next_pc);
        end else if (rst_n) begin
            assert (!reg_wr_en && !pc_update_en && !commit_en)
                else report_fail("idle outputs", 32'd0,
                                 32'({reg_wr_en, pc_update_en, commit_en}));
        end
    end

    // ====================
    // stimulus tasks
    // ====================
    task automatic run_inst(input string name, input logic [31:0] ins, input logic [31:0] rs1,
                            input logic rde, input logic cx, input logic mark);
        logic [31:0] pc;
        @(posedge clk);
        #0.5;
        pc = $urandom & 32'hFFFF_FFFE;
        cur_name = name;
        inst_vld = 1'b1;
        inst = ins;
        inst_pc = pc;
        rs1_val = rs1;
        rd_en = rde;
        c_ext = cx;
        is_intr = mark;
        inst_id = 6'($urandom);
        rd_idx = 7'($urandom);
        predict(ins, rs1, pc, rde, cx);
        @(negedge clk);
        sampled_val = reg_val;
    endtask

    task automatic issue_csr(input string name, input logic [2:0] f3, input logic [11:0] addr,
                             input logic [31:0] src);
        logic [31:0] ins;
        ins = {addr, (f3[2] ? src[4:0] : 5'd9), f3, 5'd1, OPC_SYSTEM};
        run_inst(name, ins, (f3[2] ? $urandom : src), 1'b1, 1'b0, 1'b0);
    endtask

    task automatic peek_csr(input string name, input logic [11:0] addr);
        issue_csr(name, F3_CSRRSI, addr, 32'd0);
    endtask

    task automatic idle();
        @(posedge clk);
        #0.5;
        inst_vld = 1'b0;
        is_intr = 1'b0;
    endtask

    // ack must meet a raised request, and the request drops one cycle later
    task automatic pulse_ack(input string name);
        idle();
        intr_ack = 1'b1;
        @(negedge clk);
        assert (intr_req)
            else report_fail($sformatf("%s request", name), 32'd1, 32'(intr_req));
        @(posedge clk);
        #0.5;
        intr_ack = 1'b0;
        @(negedge clk);
        assert (!intr_req)
            else report_fail($sformatf("%s drop", name), 32'd0, 32'(intr_req));
    endtask

    task automatic drive_meip(input logic v);
        idle();
        meip = v;
    endtask

    task automatic hold_low(input string name, input int cycles);
        idle();
        repeat (cycles) begin
            @(negedge clk);
            assert (!intr_req) else report_fail(name, 32'd0, 32'(intr_req));
        end
    endtask

    task automatic wait_intr(input string name);
        int n;
        idle();
        n = 0;
        @(negedge clk);
        while (!intr_req && (n < 64)) begin
            @(negedge clk);
            n++;
        end
        if (!intr_req) begin
            abort_run($sformatf("Timeout: intr_req never rose during %s", name));
        end
    endtask

    // ====================
    // directed sequence
    // ====================
    initial begin
        logic [2:0]  forms [6];
        logic [11:0] rmw_addrs [3];
        logic [31:0] src;
        logic [31:0] ins;
        logic [31:0] t0;
        forms = '{F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI, F3_CSRRSI, F3_CSRRCI};
        rmw_addrs = '{CSR_MSCRATCH, CSR_MEPC, CSR_MTVAL};
        void'($urandom(32'h6fbb73da));
        rst_n = 1'b0;
        inst_vld = 1'b0;
        inst = 32'd0;
        inst_id = 6'd0;
        inst_pc = 32'd0;
        rs1_val = 32'd0;
        rd_idx = 7'd0;
        rd_en = 1'b0;
        c_ext = 1'b0;
        is_intr = 1'b0;
        intr_ack = 1'b0;
        meip = 1'b0;
        msip = 1'b0;
        m_mstatus_mie = 1'b0;
        m_mpie = 1'b0;
        m_mie = 32'd0;
        m_mtvec = 32'd0;
        m_mscratch = 32'd0;
        m_mepc = 32'd0;
        m_mcause = 32'd0;
        m_mtval = 32'd0;
        m_mtimecmp = 64'd0;
        repeat (5) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        // read-modify-write in all six forms
        for (int a = 0; a < 3; a++) begin
            for (int f = 0; f < 6; f++) begin
                src = $urandom;
                ins = {rmw_addrs[a], src[4:0], forms[f], 5'd3, OPC_SYSTEM};
                run_inst($sformatf("rmw %h f3 %0d", rmw_addrs[a], forms[f]), ins, src,
                         1'($urandom), 1'b0, 1'b0);
            end
        end

        // mtvec mode rule, constants and unknown addresses
        issue_csr("mtvec mode held", F3_CSRRW, CSR_MTVEC, $urandom | 32'h2);
        peek_csr("mtvec readback held", CSR_MTVEC);
        issue_csr("mtvec mode written", F3_CSRRW, CSR_MTVEC,
                  ($urandom & 32'hFFFF_FFFD) | 32'h1);
        peek_csr("mtvec readback written", CSR_MTVEC);
        peek_csr("misa", CSR_MISA);
        peek_csr("mhartid", CSR_MHARTID);
        peek_csr("unknown 7ff", 12'h7FF);
        peek_csr("unknown satp", 12'h180);

        // traps
        issue_csr("mtvec base", F3_CSRRW, CSR_MTVEC, $urandom & 32'hFFFF_FFFC);
        issue_csr("mstatus enable", F3_CSRRWI, CSR_MSTATUS, 32'd8);
        run_inst("ecall", {F12_ECALL, 13'd0, OPC_SYSTEM}, 32'd0, 1'b0, 1'b0, 1'b0);
        peek_csr("ecall mepc", CSR_MEPC);
        peek_csr("ecall mcause", CSR_MCAUSE);
        peek_csr("ecall mtval", CSR_MTVAL);
        peek_csr("ecall mstatus", CSR_MSTATUS);
        run_inst("ebreak", {F12_EBREAK, 13'd0, OPC_SYSTEM}, 32'd0, 1'b0, 1'b1, 1'b0);
        peek_csr("ebreak mcause", CSR_MCAUSE);
        peek_csr("ebreak mtval", CSR_MTVAL);
        peek_csr("ebreak mstatus", CSR_MSTATUS);

        // return and sequential pc
        issue_csr("mepc target", F3_CSRRW, CSR_MEPC, $urandom & 32'hFFFF_FFFE);
        issue_csr("mstatus mpie", F3_CSRRW, CSR_MSTATUS, 32'h80);
        run_inst("mret", {F12_MRET, 13'd0, OPC_SYSTEM}, 32'd0, 1'b0, 1'b0, 1'b0);
        peek_csr("mret mstatus", CSR_MSTATUS);
        issue_csr("mstatus mie only", F3_CSRRW, CSR_MSTATUS, 32'h08);
        run_inst("mret clear mpie", {F12_MRET, 13'd0, OPC_SYSTEM}, 32'd0, 1'b0, 1'b0, 1'b0);
        peek_csr("mret set mpie", CSR_MSTATUS);
        run_inst("sequential full", NOP, 32'd0, 1'b0, 1'b0, 1'b0);
        run_inst("sequential compressed", NOP, 32'd0, 1'b0, 1'b1, 1'b0);

        // counter, eight back-to-back strobes apart
        peek_csr("mcycle first", CSR_MCYCLE);
        t0 = sampled_val;
        repeat (7) run_inst("mcycle gap", NOP, 32'd0, 1'b0, 1'b0, 1'b0);
        peek_csr("mcycle second", CSR_MCYCLE);
        assert ((sampled_val - t0) == 32'd8)
            else report_fail("mcycle delta", 32'd8, sampled_val - t0);

        // timer interrupt
        issue_csr("mtimecmph far", F3_CSRRW, CSR_MTIMECMPH, 32'hFFFF_FFFF);
        issue_csr("mtimecmp far", F3_CSRRW, CSR_MTIMECMP, 32'hFFFF_FFFF);
        issue_csr("mie mtie", F3_CSRRW, CSR_MIE, 32'h80);
        issue_csr("mstatus mie", F3_CSRRSI, CSR_MSTATUS, 32'd8);
        hold_low("timer not yet due", 8);
        issue_csr("mtimecmph near", F3_CSRRW, CSR_MTIMECMPH, 32'd0);
        issue_csr("mtimecmp near", F3_CSRRW, CSR_MTIMECMP, 32'd5);
        wait_intr("timer interrupt");
        peek_csr("mip timer", CSR_MIP);
        pulse_ack("timer ack");
        hold_low("timer blocked after ack", 6);
        run_inst("interrupt marker", NOP, 32'd0, 1'b0, 1'b0, 1'b1);
        wait_intr("timer after marker");

        // external interrupt
        issue_csr("mtimecmph far again", F3_CSRRW, CSR_MTIMECMPH, 32'hFFFF_FFFF);
        issue_csr("mie meie", F3_CSRRW, CSR_MIE, 32'h800);
        hold_low("external idle", 4);
        drive_meip(1'b1);
        wait_intr("external interrupt");
        peek_csr("mip external", CSR_MIP);
        pulse_ack("external ack");
        hold_low("external blocked after ack", 6);
        drive_meip(1'b0);

        idle();
        $display("Testbench passed");
        $finish;
    end

endmodule

/* design/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inst_vld,
    input  logic [31:0]          inst,
    input  logic [INST_ID_W-1:0] inst_id,
    input  logic [XLEN-1:0]      inst_pc,
    input  logic [XLEN-1:0]      rs1_val,
    input  logic [PHY_REG_W-1:0] rd_idx,
    input  logic                 rd_en,
    input  logic                 c_ext,
    input  logic                 is_intr,
    input  logic                 intr_ack,
    input  logic                 meip,
    input  logic                 msip,
    output logic                 reg_wr_en,
    output logic [PHY_REG_W-1:0] reg_index,
    output logic [XLEN-1:0]      reg_val,
    output logic [INST_ID_W-1:0] reg_inst_idx,
    output logic                 commit_en,
    output logic [XLEN-1:0]      next_pc,
    output logic                 pc_update_en,
    output logic [XLEN-1:0]      pc_val,
    output logic                 intr_req
);

    csr_op_e               op;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [4:0]            imm;
    logic [XLEN-1:0]       old_val;
    logic [XLEN-1:0]       wr_data;
    logic                  csr_wr_en;
    logic                  trap_en;
    logic                  mret_en;
    logic [XLEN-1:0]       mtvec;
    logic [XLEN-1:0]       mepc;
    logic                  mstatus_mie;
    logic [2:0]            mie_bits;
    logic [63:0]           cycle;
    logic [63:0]           mtimecmp;
    logic                  mtip;

    // commit side passes straight through
    assign reg_index    = rd_idx;
    assign reg_inst_idx = inst_id;
    assign commit_en    = inst_vld;

    csr_decode u_decode (.inst(inst), .op(op), .csr_addr(csr_addr), .imm(imm));

    csr_execute u_execute (
        .clk(clk), .rst_n(rst_n), .inst_vld(inst_vld), .op(op), .imm(imm),
        .rs1_val(rs1_val), .old_val(old_val), .rd_en(rd_en), .c_ext(c_ext),
        .inst_pc(inst_pc), .mtvec(mtvec), .mepc(mepc), .csr_wr_en(csr_wr_en),
        .wr_data(wr_data), .trap_en(trap_en), .mret_en(mret_en), .reg_wr_en(reg_wr_en),
        .reg_val(reg_val), .pc_update_en(pc_update_en), .pc_val(pc_val), .next_pc(next_pc)
    );

    csr_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .csr_wr_en(csr_wr_en), .csr_addr(csr_addr),
        .wr_data(wr_data), .trap_en(trap_en), .mret_en(mret_en), .op(op), .inst(inst),
        .inst_pc(inst_pc), .cycle(cycle), .mtimecmp(mtimecmp), .mtip(mtip), .meip(meip),
        .msip(msip), .old_val(old_val), .mtvec(mtvec), .mepc(mepc),
        .mstatus_mie(mstatus_mie), .mie_bits(mie_bits)
    );

    csr_timer u_timer (
        .clk(clk), .rst_n(rst_n), .csr_wr_en(csr_wr_en), .csr_addr(csr_addr),
        .wr_data(wr_data), .cycle(cycle), .mtimecmp(mtimecmp), .mtip(mtip)
    );

    csr_intr u_intr (
        .clk(clk), .rst_n(rst_n), .inst_vld(inst_vld), .is_intr(is_intr),
        .intr_ack(intr_ack), .mstatus_mie(mstatus_mie), .mie_bits(mie_bits),
        .meip(meip), .msip(msip), .mtip(mtip), .intr_req(intr_req)
    );

endmodule

/* design/csr_intr.sv */
`timescale 1ns/1ps

module csr_intr
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       inst_vld,
    input  logic       is_intr,
    input  logic       intr_ack,
    input  logic       mstatus_mie,
    input  logic [2:0] mie_bits,
    input  logic       meip,
    input  logic       msip,
    input  logic       mtip,
    output logic       intr_req
);

    logic req_sent;

    // blocked from ack until the interrupt instruction shows up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_sent <= 1'b0;
        end else if (intr_req && intr_ack) begin
            req_sent <= 1'b1;
        end else if (inst_vld && is_intr) begin
            req_sent <= 1'b0;
        end
    end

    // pending bits line up with mie_bits as {ext, timer, sw}
    assign intr_req = !req_sent && mstatus_mie && |(mie_bits & {meip, mtip, msip});

    a_req_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (intr_req && intr_ack) |=> !intr_req);

endmodule

/* design/csr_timer.sv */
`timescale 1ns/1ps

module csr_timer
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  csr_wr_en,
    input  logic [CSR_ADDR_W-1:0] csr_addr,
    input  logic [XLEN-1:0]       wr_data,
    output logic [63:0]           cycle,
    output logic [63:0]           mtimecmp,
    output logic                  mtip
);

    // free running, also serves as mtime
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= 64'd0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    // ====================
    // compare register
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= 64'd0;
        end else if (csr_wr_en) begin
            if (csr_addr == CSR_MTIMECMP) begin
                mtimecmp[31:0] <= wr_data;
            end
            if (csr_addr == CSR_MTIMECMPH) begin
                mtimecmp[63:32] <= wr_data;
            end
        end
    end

    // strictly greater, equal is not yet pending
    assign mtip = (cycle > mtimecmp);

endmodule

/* design/csr_regfile.sv */
`timescale 1ns/1ps

module csr_regfile
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  csr_wr_en,
    input  logic [CSR_ADDR_W-1:0] csr_addr,
    input  logic [XLEN-1:0]       wr_data,
    input  logic                  trap_en,
    input  logic                  mret_en,
    input  csr_op_e               op,
    input  logic [31:0]           inst,
    input  logic [XLEN-1:0]       inst_pc,
    input  logic [63:0]           cycle,
    input  logic [63:0]           mtimecmp,
    input  logic                  mtip,
    input  logic                  meip,
    input  logic                  msip,
    output logic [XLEN-1:0]       old_val,
    output logic [XLEN-1:0]       mtvec,
    output logic [XLEN-1:0]       mepc,
    output logic                  mstatus_mie,
    output logic [2:0]            mie_bits
);

    logic            mstatus_mpie;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;

    logic [XLEN-1:0] mstatus_word;
    logic [XLEN-1:0] mie_word;
    logic [XLEN-1:0] mip_word;

    // ====================
    // mstatus
    // ====================
    // trap beats mret beats a plain write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
        end else if (trap_en) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end else if (mret_en) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end else if (csr_wr_en && (csr_addr == CSR_MSTATUS)) begin
            mstatus_mie  <= wr_data[MSTATUS_MIE_BIT];
            mstatus_mpie <= wr_data[MSTATUS_MPIE_BIT];
        end
    end

    // mie_bits is {meie, mtie, msie}
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_bits <= 3'b000;
        end else if (csr_wr_en && (csr_addr == CSR_MIE)) begin
            mie_bits <= {wr_data[MIE_MEI_BIT], wr_data[MIE_MTI_BIT], wr_data[MIE_MSI_BIT]};
        end
    end

    // mode field only takes direct or vectored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec <= '0;
        end else if (csr_wr_en && (csr_addr == CSR_MTVEC)) begin
            mtvec[XLEN-1:2] <= wr_data[XLEN-1:2];
            if (!wr_data[1]) begin
                mtvec[1:0] <= wr_data[1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= '0;
        end else if (csr_wr_en && (csr_addr == CSR_MSCRATCH)) begin
            mscratch <= wr_data;
        end
    end

    // ====================
    // trap state
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else if (trap_en) begin
            mepc   <= inst_pc;
            mtval  <= inst;
            mcause <= (op == OP_ECALL) ? MCAUSE_ECALL_M : MCAUSE_BREAKPOINT;
        end else if (csr_wr_en) begin
            if (csr_addr == CSR_MEPC) begin
                mepc <= wr_data;
            end
            if (csr_addr == CSR_MCAUSE) begin
                mcause <= wr_data;
            end
            if (csr_addr == CSR_MTVAL) begin
                mtval <= wr_data;
            end
        end
    end

    // ====================
    // read mux
    // ====================
    always_comb begin
        mstatus_word = '0;
        mstatus_word[MSTATUS_MIE_BIT]  = mstatus_mie;
        mstatus_word[MSTATUS_MPIE_BIT] = mstatus_mpie;
        mie_word = '0;
        mie_word[MIE_MSI_BIT] = mie_bits[0];
        mie_word[MIE_MTI_BIT] = mie_bits[1];
        mie_word[MIE_MEI_BIT] = mie_bits[2];
        mip_word = '0;
        mip_word[MIE_MSI_BIT] = msip;
        mip_word[MIE_MTI_BIT] = mtip;
        mip_word[MIE_MEI_BIT] = meip;
    end

    always_comb begin
        case (csr_addr)
            CSR_CYCLE, CSR_TIME, CSR_MCYCLE:    old_val = cycle[31:0];
            CSR_CYCLEH, CSR_TIMEH, CSR_MCYCLEH: old_val = cycle[63:32];
            CSR_MVENDORID, CSR_MARCHID,
            CSR_MIMPID, CSR_MHARTID:            old_val = '0;
            CSR_MSTATUS:                        old_val = mstatus_word;
            CSR_MISA:                           old_val = MISA_VALUE;
            CSR_MIE:                            old_val = mie_word;
            CSR_MTVEC:                          old_val = mtvec;
            CSR_MSCRATCH:                       old_val = mscratch;
            CSR_MEPC:                           old_val = mepc;
            CSR_MCAUSE:                         old_val = mcause;
            CSR_MTVAL:                          old_val = mtval;
            CSR_MIP:                            old_val = mip_word;
            CSR_MTIMECMP:                       old_val = mtimecmp[31:0];
            CSR_MTIMECMPH:                      old_val = mtimecmp[63:32];
            default:                            old_val = '0;
        endcase
    end

    // decode never yields a csr op and a trap from one word
    a_trap_no_wr: assert property (@(posedge clk) disable iff (!rst_n)
        (csr_wr_en && ((csr_addr == CSR_MCAUSE) || (csr_addr == CSR_MTVAL))) |-> !trap_en);

endmodule

/* design/csr_execute.sv */
`timescale 1ns/1ps

module csr_execute
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            inst_vld,
    input  csr_op_e         op,
    input  logic [4:0]      imm,
    input  logic [XLEN-1:0] rs1_val,
    input  logic [XLEN-1:0] old_val,
    input  logic            rd_en,
    input  logic            c_ext,
    input  logic [XLEN-1:0] inst_pc,
    input  logic [XLEN-1:0] mtvec,
    input  logic [XLEN-1:0] mepc,
    output logic            csr_wr_en,
    output logic [XLEN-1:0] wr_data,
    output logic            trap_en,
    output logic            mret_en,
    output logic            reg_wr_en,
    output logic [XLEN-1:0] reg_val,
    output logic            pc_update_en,
    output logic [XLEN-1:0] pc_val,
    output logic [XLEN-1:0] next_pc
);

    logic            is_imm;
    logic            is_csr_op;
    logic [XLEN-1:0] operand;

    assign is_imm    = (op == OP_CSRRWI) || (op == OP_CSRRSI) || (op == OP_CSRRCI);
    assign is_csr_op = is_imm || (op == OP_CSRRW) || (op == OP_CSRRS) || (op == OP_CSRRC);
    assign operand   = is_imm ? {{(XLEN-5){1'b0}}, imm} : rs1_val;

    // ====================
    // csr read-modify-write
    // ====================
    always_comb begin
        case (op)
            OP_CSRRS, OP_CSRRSI: wr_data = old_val | operand;
            OP_CSRRC, OP_CSRRCI: wr_data = old_val & ~operand;
            default:             wr_data = operand;
        endcase
    end

    // set/clear with zero operand still rewrites the old value
    assign csr_wr_en = inst_vld && is_csr_op;
    assign reg_wr_en = csr_wr_en && rd_en;
    assign reg_val   = old_val;

    // ====================
    // trap and return
    // ====================
    assign trap_en      = inst_vld && ((op == OP_ECALL) || (op == OP_EBREAK));
    assign mret_en      = inst_vld && (op == OP_MRET);
    assign pc_update_en = trap_en || mret_en;
    assign pc_val       = trap_en ? mtvec : (mret_en ? mepc : '0);

    // sequential pc steps by the instruction length
    assign next_pc = pc_update_en ? pc_val : (inst_pc + (c_ext ? 32'd2 : 32'd4));

    a_trap_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(trap_en && mret_en));

    a_redirect_vld: assert property (@(posedge clk) disable iff (!rst_n)
        pc_update_en |-> inst_vld);

endmodule

/* design/csr_decode.sv */
`timescale 1ns/1ps

module csr_decode
    import csr_pkg::*;
(
    input  logic [31:0]           inst,
    output csr_op_e               op,
    output logic [CSR_ADDR_W-1:0] csr_addr,
    output logic [4:0]            imm
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] funct12;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct12  = inst[31:20];

    // csr address sits in the funct12 field, uimm in rs1
    assign csr_addr = funct12;
    assign imm      = inst[19:15];

    always_comb begin
        op = OP_NONE;
        if (opcode == OPC_SYSTEM) begin
            case (funct3)
                F3_CSRRW:  op = OP_CSRRW;
                F3_CSRRS:  op = OP_CSRRS;
                F3_CSRRC:  op = OP_CSRRC;
                F3_CSRRWI: op = OP_CSRRWI;
                F3_CSRRSI: op = OP_CSRRSI;
                F3_CSRRCI: op = OP_CSRRCI;
                F3_PRIV: begin
                    case (funct12)
                        F12_ECALL:  op = OP_ECALL;
                        F12_EBREAK: op = OP_EBREAK;
                        F12_MRET:   op = OP_MRET;
                        default:    op = OP_NONE;
                    endcase
                end
                default:   op = OP_NONE;
            endcase
        end
    end

endmodule

/* design/csr_pkg.sv */
package csr_pkg;

    // ====================
    // widths
    // ====================
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;
    localparam int INST_ID_W  = 6;
    localparam int PHY_REG_W  = 7;

    // ====================
    // instruction fields
    // ====================
    localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0]  F3_PRIV    = 3'b000;
    localparam logic [2:0]  F3_CSRRW   = 3'b001;
    localparam logic [2:0]  F3_CSRRS   = 3'b010;
    localparam logic [2:0]  F3_CSRRC   = 3'b011;
    localparam logic [2:0]  F3_CSRRWI  = 3'b101;
    localparam logic [2:0]  F3_CSRRSI  = 3'b110;
    localparam logic [2:0]  F3_CSRRCI  = 3'b111;

    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET   = 12'h302;

    // trap causes, synchronous only
    localparam logic [XLEN-1:0] MCAUSE_ECALL_M    = 32'd11;
    localparam logic [XLEN-1:0] MCAUSE_BREAKPOINT = 32'd3;

    // mxl = 1, only the I extension
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100;

    // bit positions inside mstatus, mie and mip
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIE_MSI_BIT      = 3;
    localparam int MIE_MTI_BIT      = 7;
    localparam int MIE_MEI_BIT      = 11;

    typedef enum logic [3:0] {
        OP_NONE,
        OP_CSRRW,
        OP_CSRRS,
        OP_CSRRC,
        OP_CSRRWI,
        OP_CSRRSI,
        OP_CSRRCI,
        OP_ECALL,
        OP_EBREAK,
        OP_MRET
    } csr_op_e;

    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_CYCLE     = 12'hC00,
        CSR_TIME      = 12'hC01,
        CSR_CYCLEH    = 12'hC80,
        CSR_TIMEH     = 12'hC81,
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14,
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MIP       = 12'h344,
        CSR_MCYCLE    = 12'hB00,
        CSR_MCYCLEH   = 12'hB80,
        // non-standard timer compare
        CSR_MTIMECMP  = 12'h7C0,
        CSR_MTIMECMPH = 12'h7C1
    } csr_addr_e;

endpackage
